//--- design/dram_array.sv
// Top level of the banked distributed RAM with decoder, bank array and read selector
`timescale 1ns/100ps
`include "dram_cfg.svh"

module dram_array (
  input  logic                    clk,
  input  logic                    we,
  input  logic [`DRAM_ADDR_W-1:0] a,
  input  dram_pkg::data_t         d,
  output dram_pkg::data_t         spo
);

  // Address map
  //   a[ADDR_W-1 : OFFSET_W]  bank number
  //   a[OFFSET_W-1 : 0]       word inside the bank

  // Incoming address seen through the union
  dram_pkg::addr_u a_u;

  // One write enable per bank from the decoder
  logic [`DRAM_BANKS-1:0] bank_we;

  // Offset shared by all banks
  dram_pkg::offset_t bank_a;

  // Read word of every bank toward the selector
  dram_pkg::data_t bank_spo [`DRAM_BANKS];

  assign a_u.flat = a;

  // Write steering
  dram_write_decode dram_write_decode_i (
    .we      (we),
    .a       (a_u),
    .bank_we (bank_we),
    .bank_a  (bank_a)
  );

  // Bank array
  // Every bank gets the same data and offset
  // Only its own enable lets a write through
  for (genvar i = 0; i < `DRAM_BANKS; i++) begin : gen_bank
    dram_bank dram_bank_i (
      .clk (clk),
      .we  (bank_we[i]),
      .a   (bank_a),
      .d   (d),
      .spo (bank_spo[i])
    );
  end

  // Read path back to a single word
  dram_read_select dram_read_select_i (
    .bank_sel (a_u.fields.bank),
    .bank_spo (bank_spo),
    .spo      (spo)
  );

endmodule

//--- design/dram_bank.sv
// Single distributed RAM bank with synchronous write and asynchronous read
`timescale 1ns/100ps
`include "dram_cfg.svh"

module dram_bank (
  input  logic              clk,
  input  logic              we,
  input  dram_pkg::offset_t a,
  input  dram_pkg::data_t   d,
  output dram_pkg::data_t   spo
);

  // Storage array
  // Contents are undefined until a location is written
  dram_pkg::data_t mem [`DRAM_BANK_DEPTH];

  // Combinational read word taken straight from the array
  dram_pkg::data_t mem_out;

  // Write port
  // One word is written per rising edge while we is high
  always_ff @(posedge clk) begin
    if (we) begin
      mem[a] <= d;
    end
  end

  // Read port
  // Zero latency, the word follows a as soon as it settles
  // A write to the addressed word shows here right after the edge
  always_comb begin
    mem_out = mem[a];
  end

  // Output tap of the read word
  assign spo = mem_out;

endmodule

//--- design/dram_cfg.svh
// Size and width macros for the banked distributed RAM
`ifndef DRAM_CFG_SVH
`define DRAM_CFG_SVH

// Full word address into the array
`define DRAM_ADDR_W 6

// Width of one stored word
`define DRAM_DATA_W 32

// Upper address bits that pick the bank
`define DRAM_BANK_BITS 2

// Lower address bits that index inside one bank
`define DRAM_OFFSET_W (`DRAM_ADDR_W - `DRAM_BANK_BITS)

// Number of banks
`define DRAM_BANKS (1 << `DRAM_BANK_BITS)

// Words held by each bank
`define DRAM_BANK_DEPTH (1 << `DRAM_OFFSET_W)

// Total capacity is DRAM_BANKS * DRAM_BANK_DEPTH words

`endif

//--- design/dram_pkg.sv
// Data word, address field and address union types for the banked RAM
`include "dram_cfg.svh"

package dram_pkg;

  // One stored word
  typedef logic [`DRAM_DATA_W-1:0] data_t;

  // Bank number taken from the upper address bits
  typedef logic [`DRAM_BANK_BITS-1:0] bank_t;

  // Word index inside a single bank
  typedef logic [`DRAM_OFFSET_W-1:0] offset_t;

  // Address split into bank and offset
  // Bank sits in the upper bits so that consecutive flat addresses
  // stay inside one bank until its offset wraps
  typedef struct packed {
    bank_t   bank;
    offset_t offset;
  } addr_fields_t;

  // Same address bits seen either way
  // flat is what the user drives
  // fields is what the decoder and selector work from
  typedef union packed {
    logic [`DRAM_ADDR_W-1:0] flat;
    addr_fields_t            fields;
  } addr_u;

  // Flat view and split view must have the same width
  // The union definition enforces this at compile time

endpackage

//--- design/dram_read_select.sv
// Read selector that puts the addressed bank's word on the output
`timescale 1ns/100ps
`include "dram_cfg.svh"

module dram_read_select (
  input  dram_pkg::bank_t bank_sel,
  input  dram_pkg::data_t bank_spo [`DRAM_BANKS],
  output dram_pkg::data_t spo
);

  // AND-OR multiplexer over all banks
  // Exactly one term is active for a known bank_sel
  // Same bank field as the write decoder, so a flat address
  // always lands on a single location for both reads and writes
  always_comb begin
    spo = '0;
    for (int i = 0; i < `DRAM_BANKS; i++) begin
      if (bank_sel == dram_pkg::bank_t'(i)) begin
        spo = bank_spo[i];
      end
    end
  end

endmodule

//--- design/dram_write_decode.sv
// Write decoder that turns one address and strobe into per-bank enables and an offset
`timescale 1ns/100ps
`include "dram_cfg.svh"

module dram_write_decode (
  input  logic                    we,
  input  dram_pkg::addr_u         a,
  output logic [`DRAM_BANKS-1:0]  bank_we,
  output dram_pkg::offset_t       bank_a
);

  // Bank field of the incoming address
  dram_pkg::bank_t bank_sel;

  assign bank_sel = a.fields.bank;

  // One-hot enable per bank
  // All zero while we is low so no bank sees a write
  always_comb begin
    bank_we = '0;
    for (int i = 0; i < `DRAM_BANKS; i++) begin
      if (we && (bank_sel == dram_pkg::bank_t'(i))) begin
        bank_we[i] = 1'b1;
      end
    end
  end

  // Offset is shared by every bank
  // Only the enabled bank stores the word, the others just read it
  assign bank_a = a.fields.offset;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the banked RAM testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module dram_array_tb \
  -Mdir obj_dir \
  -f sim.f \
  || { echo "Build failed"; exit 1; }

./obj_dir/Vdram_array_tb | tee /dev/stderr | grep -q "TEST OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim.f
+incdir+design
design/dram_pkg.sv
design/dram_bank.sv
design/dram_write_decode.sv
design/dram_read_select.sv
design/dram_array.sv
tests/dram_array_sva.sv
tests/dram_array_tb.sv

//--- tests/dram_array_sva.sv
// Concurrent assertions for the banked RAM with a shadow model of its contents
`timescale 1ns/100ps
`include "dram_cfg.svh"

module dram_array_sva (
  input logic                    clk,
  input logic                    we,
  input logic [`DRAM_ADDR_W-1:0] a,
  input dram_pkg::data_t         d,
  input dram_pkg::data_t         spo
);

  localparam int WORDS = `DRAM_BANKS * `DRAM_BANK_DEPTH;

  // Model of the array, a location counts only once written
  dram_pkg::data_t model [WORDS];
  bit              known [WORDS];
  bit              past_valid;

  // Model word at the current address
  dram_pkg::data_t model_word;
  bit              model_known;

  // Number of failed assertions so far
  int fail_total;

  always_ff @(posedge clk) begin
    past_valid <= 1'b1;
    if (we) begin
      model[a] <= d;
      known[a] <= 1'b1;
    end
  end

  always_comb begin
    model_word = model[a];
    model_known = known[a];
  end

  write_inputs_known: assert property (@(posedge clk)
    we |-> !$isunknown(a) && !$isunknown(d))
    else begin
      $error("Write with unknown address or data");
      fail_total++;
    end

  read_matches_model: assert property (@(posedge clk)
    model_known |-> spo == model_word)
    else begin
      $error("Read word differs from the model at address %0d", a);
      fail_total++;
    end

  // Write at one edge, same address at the next
  write_readback: assert property (@(posedge clk)
    past_valid && $past(we) && (a == $past(a)) |-> spo == $past(d))
    else begin
      $error("Written word not seen on the read port at address %0d", a);
      fail_total++;
    end

  idle_stable: assert property (@(posedge clk)
    past_valid && !$past(we) && $stable(a) && model_known |-> $stable(spo))
    else begin
      $error("Read word changed while idle at address %0d", a);
      fail_total++;
    end

  spo_known: assert property (@(posedge clk)
    model_known |-> !$isunknown(spo))
    else begin
      $error("Unknown read word at written address %0d", a);
      fail_total++;
    end

endmodule

//--- tests/dram_array_tb.sv
// Testbench for the banked RAM with xorshift stimulus, shadow array checks and reporting
`timescale 1ns/100ps
`include "dram_cfg.svh"

module dram_array_tb;

  localparam int ADDR_W = `DRAM_ADDR_W;
  localparam int WORDS = `DRAM_BANKS * `DRAM_BANK_DEPTH;
  localparam int RANDOM_CYCLES = 400;
  localparam int IDLE_CYCLES = 8;
  // All tests together run for under 600 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic              clk;
  logic              rst_n;
  logic              we;
  logic [ADDR_W-1:0] a;
  dram_pkg::data_t   d;
  dram_pkg::data_t   spo;

  // Expected contents, kept from the write rule alone
  dram_pkg::data_t shadow [WORDS];
  bit              written [WORDS];

  logic [31:0] rng;
  string       test_name;
  int          test_errors;
  int          test_checks;
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  int          sva_seen;
  bit          hit_lo;
  bit          hit_hi;

  dram_array dram_array_i (
    .clk (clk),
    .we  (we),
    .a   (a),
    .d   (d),
    .spo (spo)
  );

  bind dram_array dram_array_sva dram_array_sva_i (
    .clk (clk),
    .we  (we),
    .a   (a),
    .d   (d),
    .spo (spo)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic end_test();
    int sva_new;
    // Concurrent assertion failures since the last test count against this one
    sva_new = dram_array_i.dram_array_sva_i.fail_total - sva_seen;
    sva_seen = dram_array_i.dram_array_sva_i.fail_total;
    if (sva_new != 0) begin
      $display("%s: %0d concurrent assertion failures", test_name, sva_new);
      test_errors += sva_new;
    end
    if (test_errors == 0) begin
      pass_count++;
      $display("%s: pass, %0d checks", test_name, test_checks);
    end else begin
      fail_count++;
      $display("%s: fail, %0d errors in %0d checks", test_name, test_errors, test_checks);
    end
  endtask

  // Compare the read word against the shadow once the location holds data
  task automatic check_word(input logic [ADDR_W-1:0] addr);
    if (rst_n && written[addr]) begin
      test_checks++;
      assert (spo === shadow[addr]) else begin
        $display("MISMATCH %s addr %0d expected %h actual %h",
                 test_name, addr, shadow[addr], spo);
        test_errors++;
      end
    end
  endtask

  // Called at a falling edge, drives one access and checks it one cycle later
  task automatic access(input logic wr, input logic [ADDR_W-1:0] addr,
                        input dram_pkg::data_t data);
    we = wr;
    a = addr;
    d = data;
    if (wr) begin
      shadow[addr] = data;
      written[addr] = 1'b1;
    end
    if (addr == '0) begin
      hit_lo = 1'b1;
    end
    if (addr == '1) begin
      hit_hi = 1'b1;
    end
    @(negedge clk);
    check_word(addr);
  endtask

  task automatic fill_readback();
    dram_pkg::data_t v;
    start_test("fill_readback");
    for (int i = 0; i < WORDS; i++) begin
      rng = xorshift32(rng);
      v = dram_pkg::data_t'(rng);
      access(1'b1, ADDR_W'(i), v);
    end
    for (int i = 0; i < WORDS; i++) begin
      access(1'b0, ADDR_W'(i), '0);
    end
    end_test();
  endtask

  // Same offset in every bank, all banks reread after each write
  task automatic bank_isolation();
    dram_pkg::addr_u   au;
    dram_pkg::offset_t off;
    dram_pkg::data_t   v;
    start_test("bank_isolation");
    rng = xorshift32(rng);
    off = dram_pkg::offset_t'(rng);
    for (int b = 0; b < `DRAM_BANKS; b++) begin
      rng = xorshift32(rng);
      v = dram_pkg::data_t'(rng) ^ dram_pkg::data_t'(b);
      au.fields.bank = dram_pkg::bank_t'(b);
      au.fields.offset = off;
      access(1'b1, au.flat, v);
      for (int r = 0; r < `DRAM_BANKS; r++) begin
        au.fields.bank = dram_pkg::bank_t'(r);
        access(1'b0, au.flat, '0);
      end
    end
    end_test();
  endtask

  task automatic write_then_read();
    logic [ADDR_W-1:0] addr;
    start_test("write_then_read");
    rng = xorshift32(rng);
    addr = ADDR_W'(rng);
    rng = xorshift32(rng);
    access(1'b1, addr, dram_pkg::data_t'(rng));
    // Back-to-back writes, the last one must stick
    repeat (3) begin
      rng = xorshift32(rng);
      access(1'b1, addr, dram_pkg::data_t'(rng));
    end
    access(1'b0, addr, '0);
    end_test();
  endtask

  task automatic idle_hold();
    logic [ADDR_W-1:0] addr;
    dram_pkg::data_t   held;
    start_test("idle_hold");
    rng = xorshift32(rng);
    addr = ADDR_W'(rng);
    access(1'b0, addr, '0);
    held = shadow[addr];
    repeat (IDLE_CYCLES) begin
      rng = xorshift32(rng);
      access(1'b0, addr, dram_pkg::data_t'(rng));
      test_checks++;
      assert (spo === held) else begin
        $display("MISMATCH %s addr %0d expected %h actual %h", test_name, addr, held, spo);
        test_errors++;
      end
    end
    end_test();
  endtask

  task automatic random_mix();
    logic [31:0]       r;
    logic [ADDR_W-1:0] addr;
    start_test("random_mix");
    hit_lo = 1'b0;
    hit_hi = 1'b0;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      rng = xorshift32(rng);
      r = rng;
      // About one access in eight goes to an end of the address range
      if (r[12:10] == 3'b000) begin
        addr = r[13] ? '1 : '0;
      end else begin
        addr = r[ADDR_W:1];
      end
      rng = xorshift32(rng);
      access(r[0], addr, dram_pkg::data_t'(rng));
    end
    assert (hit_lo && hit_hi) else begin
      $display("Random mix did not reach both address 0 and address %0d", WORDS - 1);
      test_errors++;
    end
    end_test();
  endtask

  initial begin
    rst_n = 1'b0;
    we = 1'b0;
    a = '0;
    d = '0;
    rng = 32'h4120;
    pass_count = 0;
    fail_count = 0;
    cycle_count = 0;
    sva_seen = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fill_readback();
    bank_isolation();
    write_then_read();
    idle_hold();
    random_mix();

    we = 1'b0;
    $display("Tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
